// File: all.f
rtl/mlse_pkg.sv
rtl/path_select.sv
rtl/isi_conv.sv
rtl/state_unit.sv
rtl/branch_metric.sv
rtl/mlse_ctrl.sv
rtl/mlse_top.sv
tb/mlse_tb.sv

// File: tb/mlse_tb.sv
module mlse_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mlse_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_SYMS        = 1200;
    localparam int NOISELESS_SYMS  = 200;   // The rest get a +1 or -1 noise term
    localparam int BP_FIRST        = 100;
    localparam int BP_LAST         = 109;
    localparam int BP_STALL        = 40;
    localparam int WATCHDOG_CYCLES = NUM_SYMS * 20 + RESET_CYCLES;

    logic                        clk;
    logic                        rst_n;
    sample_t [CH_TAPS-1:0]       est_channel;
    logic                        in_req;
    logic                        in_ack;
    sample_t                     in_sample;
    logic                        out_req;
    logic                        out_ack;
    sym_t                        out_sym;

    logic [31:0] lfsr;
    int          tap_val [CH_TAPS];
    int          sent    [NUM_SYMS];        // Symbols as +1 or -1
    int          noise   [NUM_SYMS];
    int          stall   [NUM_SYMS];        // Sink delay before out_ack for each decision
    int          hold    [NUM_SYMS];        // Source delay before dropping in_req
    sym_t        got_q   [$];
    int          checked;
    int          mismatch_errors;
    int          protocol_errors;
    int          timeout_errors;

    // Handshake monitor state
    logic prev_in_req;
    logic prev_in_ack;
    logic prev_out_req;
    logic prev_out_ack;
    int   edge_cnt;
    int   req_edge;

    mlse_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .est_channel(est_channel),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_sample  (in_sample),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_sym    (out_sym)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD000_0001;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Noiseless received value from the channel taps and the last CH_TAPS symbols
    function automatic int ref_sample(input int n);
        int acc;
        acc = 0;
        for (int k = 0; k < CH_TAPS; k++) begin
            if (n - k >= 0) begin
                acc += tap_val[k] * sent[n-k];
            end
        end
        return acc;
    endfunction

    function automatic int expected_decision(input int n);
        if (n < H_DEPTH) begin
            return 0;                       // Histories still hold the fill value
        end
        return sent[n-H_DEPTH];
    endfunction

    function automatic string test_name(input int n);
        if (n < H_DEPTH) begin
            return "reset_fill";
        end else if (n >= BP_FIRST && n <= BP_LAST) begin
            return "backpressure";
        end else if (n < NOISELESS_SYMS) begin
            return "noiseless";
        end
        return "renorm";
    endfunction

    task automatic make_stimulus();
        int b;
        for (int n = 0; n < NUM_SYMS; n++) begin
            take_bits(1, b);
            sent[n] = b ? 1 : -1;
            if (n >= NOISELESS_SYMS) begin
                take_bits(1, b);
                noise[n] = b ? 1 : -1;
            end else begin
                noise[n] = 0;
            end
            take_bits(2, b);
            stall[n] = (n >= BP_FIRST && n <= BP_LAST) ? BP_STALL : b;
            take_bits(2, b);
            hold[n] = b;
        end
    endtask

    task automatic send_samples();
        for (int n = 0; n < NUM_SYMS; n++) begin
            @(posedge clk);
            while (in_ack) begin
                @(posedge clk);
            end
            in_sample <= sample_t'(ref_sample(n) + noise[n]);
            in_req    <= 1'b1;
            do begin
                @(posedge clk);
            end while (!in_ack);
            repeat (hold[n]) @(posedge clk);
            in_req <= 1'b0;
        end
    endtask

    task automatic take_decisions();
        sym_t first;
        for (int n = 0; n < NUM_SYMS; n++) begin
            do begin
                @(posedge clk);
            end while (!out_req);
            first = out_sym;
            repeat (stall[n]) @(posedge clk);
            if (out_sym !== first) begin
                $display("out_sym changed while out_req was high at decision %0d", n);
                protocol_errors++;
            end
            out_ack <= 1'b1;
            do begin
                @(posedge clk);
            end while (out_req);
            out_ack <= 1'b0;
            got_q.push_back(first);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatch, %0d protocol, %0d timeout",
                 mismatch_errors, protocol_errors, timeout_errors);
        if (mismatch_errors + protocol_errors + timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Decisions are compared in arrival order against the decision rule
    always @(posedge clk) begin
        sym_t got;
        int   exp;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            exp = expected_decision(checked);
            if (got !== sym_t'(exp)) begin
                $display("Mismatch %s: decision %0d expected %0d actual %0d",
                         test_name(checked), checked, exp, got);
                mismatch_errors++;
            end
            checked++;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (in_req && !prev_in_req) begin
                req_edge = edge_cnt;
            end
            if (in_ack && !prev_in_ack) begin
                if (edge_cnt - req_edge != 2) begin
                    $display("in_ack rose %0d edges after in_req instead of 2",
                             edge_cnt - req_edge);
                    protocol_errors++;
                end
                if (!(out_req && !prev_out_req)) begin
                    $display("in_ack rose without out_req rising on the same edge");
                    protocol_errors++;
                end
            end
            if (out_req && !prev_out_req && !(in_ack && !prev_in_ack)) begin
                $display("out_req rose without in_ack rising on the same edge");
                protocol_errors++;
            end
            if (!in_ack && prev_in_ack && prev_in_req) begin
                $display("in_ack fell while in_req was still high");
                protocol_errors++;
            end
            if (!out_req && prev_out_req && !prev_out_ack) begin
                $display("out_req fell before out_ack was raised");
                protocol_errors++;
            end
        end
        prev_in_req  = in_req;
        prev_in_ack  = in_ack;
        prev_out_req = out_req;
        prev_out_ack = out_ack;
        edge_cnt++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        timeout_errors++;
        finish_run();
    end

    initial begin
        lfsr            = 32'h3505_1a24;
        tap_val         = '{64, 24, -12, 6};
        checked         = 0;
        mismatch_errors = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        prev_in_req     = 1'b0;
        prev_in_ack     = 1'b0;
        prev_out_req    = 1'b0;
        prev_out_ack    = 1'b0;
        edge_cnt        = 0;
        req_edge        = -1;
        rst_n           = 1'b0;
        in_req          = 1'b0;
        in_sample       = '0;
        out_ack         = 1'b0;
        for (int k = 0; k < CH_TAPS; k++) begin
            est_channel[k] = sample_t'(tap_val[k]);   // Static for the whole run
        end
        make_stimulus();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (in_ack !== 1'b0 || out_req !== 1'b0) begin
            $display("in_ack or out_req was not low right after reset");
            protocol_errors++;
        end

        fork
            send_samples();
            take_decisions();
        join
        repeat (3) @(posedge clk);

        // Every sample must give exactly one decision
        if (checked != NUM_SYMS) begin
            $display("Only %0d of %0d decisions were checked", checked, NUM_SYMS);
            protocol_errors++;
        end
        finish_run();
    end

endmodule

// File: rtl/mlse_top.sv
module mlse_top #(
    parameter int SAMPLE_W = mlse_pkg::SAMPLE_W,
    parameter int H_DEPTH  = mlse_pkg::H_DEPTH,
    parameter int CH_TAPS  = mlse_pkg::CH_TAPS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mlse_pkg::sample_t [CH_TAPS-1:0] est_channel,
    input  logic                            in_req,
    output logic                            in_ack,
    input  mlse_pkg::sample_t               in_sample,
    output logic                            out_req,
    input  logic                            out_ack,
    output mlse_pkg::sym_t                  out_sym
);
    import mlse_pkg::*;

    sample_t       sample;
    logic          step;
    wire path_t    [1:0] survivors;  // Each element comes from its own state unit
    wire sample_t  [1:0] isi;
    path_t         [3:0] cand;
    path_t         best;

    mlse_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_sample (in_sample),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_sym   (out_sym),
        .sample    (sample),
        .step      (step),
        .oldest_sym(best.hist[H_DEPTH-1])
    );

    branch_metric #(
        .SAMPLE_W(SAMPLE_W),
        .H_DEPTH (H_DEPTH)
    ) u_branch (
        .survivors(survivors),
        .isi      (isi),
        .tap0     (est_channel[0]),
        .sample   (sample),
        .cand     (cand)
    );

    for (genvar g = 0; g < 2; g++) begin : g_state
        state_unit #(
            .SAMPLE_W(SAMPLE_W),
            .H_DEPTH (H_DEPTH),
            .CH_TAPS (CH_TAPS),
            .TAG_IDX (g)
        ) u_state (
            .clk        (clk),
            .rst_n      (rst_n),
            .step       (step),
            .cand       (cand[2*g +: 2]),
            .norm_energy(best.energy),
            .taps       (est_channel[CH_TAPS-1:1]),
            .survivor   (survivors[g]),
            .isi        (isi[g])
        );
    end

    // Best of the two states feeds both renormalization and the decision
    path_select #(
        .N(2)
    ) u_best (
        .cand(survivors),
        .best(best)
    );

endmodule

// File: rtl/mlse_ctrl.sv
module mlse_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_req,
    output logic              in_ack,
    input  mlse_pkg::sample_t in_sample,
    output logic              out_req,
    input  logic              out_ack,
    output mlse_pkg::sym_t    out_sym,
    output mlse_pkg::sample_t sample,       // Held for the branch metrics during the step
    output logic              step,
    input  mlse_pkg::sym_t    oldest_sym    // Oldest symbol of the best survivor
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STEP,
        S_OUT,
        S_RELEASE
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (in_req) begin
                    state_nxt = S_STEP;
                end
            end
            S_STEP: begin
                state_nxt = S_OUT;
            end
            S_OUT: begin
                if (out_ack) begin
                    state_nxt = S_RELEASE;
                end
            end
            S_RELEASE: begin
                // Both sides must have finished their return to zero
                if (!in_req && !out_ack) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    assign step = (state == S_STEP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            state <= state_nxt;
            // The sample is acknowledged and the decision offered on the same edge
            if (state == S_STEP) begin
                in_ack  <= 1'b1;
                out_req <= 1'b1;
            end
            if (state == S_OUT && out_ack) begin
                out_req <= 1'b0;
            end
            if (state == S_RELEASE && state_nxt == S_IDLE) begin
                in_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && in_req) begin
            sample <= in_sample;
        end
        if (state == S_STEP) begin
            out_sym <= oldest_sym;  // Survivors have not moved yet on this cycle
        end
    end

endmodule

// File: rtl/branch_metric.sv
module branch_metric #(
    parameter int SAMPLE_W = mlse_pkg::SAMPLE_W,
    parameter int H_DEPTH  = mlse_pkg::H_DEPTH
) (
    input  mlse_pkg::path_t   [1:0] survivors,
    input  mlse_pkg::sample_t [1:0] isi,
    input  mlse_pkg::sample_t       tap0,
    input  mlse_pkg::sample_t       sample,
    output mlse_pkg::path_t   [3:0] cand        // Index is 2 * destination + source
);
    import mlse_pkg::*;

    // The prediction can reach twice full scale, the error three times
    localparam int ERR_W = SAMPLE_W + 2;
    localparam int SQ_W  = 2 * ERR_W;
    localparam int SUM_W = SQ_W + 1;

    logic signed [ERR_W-1:0] pred;
    logic signed [ERR_W-1:0] err;
    logic signed [SQ_W-1:0]  sq;
    logic [SUM_W-1:0]        sum;

    always_comb begin
        for (int d = 0; d < 2; d++) begin
            for (int s = 0; s < 2; s++) begin
                // New symbol times tap 0 is just a sign flip
                pred = ERR_W'(isi[s]);
                if (STATE_TAG[d] == SYM_PLUS) begin
                    pred = pred + ERR_W'(tap0);
                end else begin
                    pred = pred - ERR_W'(tap0);
                end

                err = ERR_W'(sample) - pred;
                sq  = err * err;
                sum = SUM_W'(sq) + SUM_W'(survivors[s].energy);

                if (|sum[SUM_W-1:ENERGY_W]) begin
                    cand[2*d+s].energy = '1;      // Pin at the top instead of wrapping
                end else begin
                    cand[2*d+s].energy = sum[ENERGY_W-1:0];
                end

                // Oldest symbol drops off as the destination tag enters
                cand[2*d+s].hist = {survivors[s].hist[H_DEPTH-2:0], STATE_TAG[d]};
            end
        end
    end

endmodule

// File: rtl/state_unit.sv
module state_unit #(
    parameter int SAMPLE_W = mlse_pkg::SAMPLE_W,
    parameter int H_DEPTH  = mlse_pkg::H_DEPTH,
    parameter int CH_TAPS  = mlse_pkg::CH_TAPS,
    parameter int TAG_IDX  = 0
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            step,
    input  mlse_pkg::path_t   [1:0]         cand,         // The two paths ending in this state
    input  mlse_pkg::energy_t               norm_energy,  // Best energy before this step
    input  mlse_pkg::sample_t [CH_TAPS-2:0] taps,
    output mlse_pkg::path_t                 survivor,
    output mlse_pkg::sample_t               isi
);
    import mlse_pkg::*;

    path_t              winner;
    sym_t [H_DEPTH-1:0] next_hist;
    energy_t            next_energy;
    sample_t            next_isi;

    path_select #(
        .N(2)
    ) u_select (
        .cand(cand),
        .best(winner)
    );

    // Forcing the tag keeps the tap 1 term constant for this state
    always_comb begin
        next_hist    = winner.hist;
        next_hist[0] = STATE_TAG[TAG_IDX];
    end

    // Interference for the next step is worked out ahead from the new history
    isi_conv #(
        .SAMPLE_W(SAMPLE_W),
        .H_DEPTH (H_DEPTH),
        .CH_TAPS (CH_TAPS)
    ) u_conv (
        .hist(next_hist),
        .taps(taps),
        .isi (next_isi)
    );

    // Energies are kept relative to the best path of the last step
    assign next_energy = (winner.energy > norm_energy) ? winner.energy - norm_energy : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            survivor.energy <= '0;
            survivor.hist   <= {H_DEPTH{SYM_FILL}};
            isi             <= '0;
        end else if (step) begin
            survivor.energy <= next_energy;
            survivor.hist   <= next_hist;
            isi             <= next_isi;
        end
    end

endmodule

// File: rtl/isi_conv.sv
module isi_conv #(
    parameter int SAMPLE_W = mlse_pkg::SAMPLE_W,
    parameter int H_DEPTH  = mlse_pkg::H_DEPTH,
    parameter int CH_TAPS  = mlse_pkg::CH_TAPS
) (
    input  mlse_pkg::sym_t    [H_DEPTH-1:0] hist,
    input  mlse_pkg::sample_t [CH_TAPS-2:0] taps,  // Taps 1 to CH_TAPS-1
    output mlse_pkg::sample_t               isi
);
    import mlse_pkg::*;

    // Enough headroom for CH_TAPS-1 full scale terms before saturating
    localparam int ACC_W = SAMPLE_W + $clog2(CH_TAPS) + 1;
    localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(-(2 ** (SAMPLE_W - 1)));

    logic signed [ACC_W-1:0] acc;

    always_comb begin
        acc = '0;
        // hist[k] lines up with tap k+1 since the new symbol takes tap 0
        for (int k = 0; k < CH_TAPS - 1; k++) begin
            case (hist[k])
                SYM_PLUS: begin
                    acc = acc + ACC_W'(taps[k]);
                end
                SYM_MINUS: begin
                    acc = acc - ACC_W'(taps[k]);
                end
                default: begin
                    acc = acc;                    // Fill symbols add nothing
                end
            endcase
        end

        if (acc > SAT_MAX) begin
            isi = SAT_MAX[SAMPLE_W-1:0];
        end else if (acc < SAT_MIN) begin
            isi = SAT_MIN[SAMPLE_W-1:0];
        end else begin
            isi = acc[SAMPLE_W-1:0];
        end
    end

endmodule

// File: rtl/path_select.sv
module path_select #(
    parameter int N = 2
) (
    input  mlse_pkg::path_t [N-1:0] cand,
    output mlse_pkg::path_t         best
);
    import mlse_pkg::*;

    localparam int LEVELS = (N > 1) ? $clog2(N) : 0;
    localparam int LEAVES = 1 << LEVELS;

    // Heap order with the root at node 1 and leaf i at LEAVES + i
    path_t node [1:2*LEAVES-1];

    always_comb begin
        for (int i = 0; i < LEAVES; i++) begin
            if (i < N) begin
                node[LEAVES+i] = cand[i];
            end else begin
                node[LEAVES+i] = '{energy: '1, hist: '0}; // Padding sits right of every real leaf
            end
        end

        // The left child always covers the lower indices, so it keeps a tie
        for (int i = LEAVES - 1; i >= 1; i--) begin
            if (node[2*i+1].energy < node[2*i].energy) begin
                node[i] = node[2*i+1];
            end else begin
                node[i] = node[2*i];
            end
        end
    end

    assign best = node[1];

endmodule

// File: rtl/mlse_pkg.sv
package mlse_pkg;

    localparam int SAMPLE_W = 10;             // Received samples and channel taps
    localparam int H_DEPTH  = 8;              // Survivor length, which is also the decision delay
    localparam int CH_TAPS  = 4;              // Must not exceed H_DEPTH + 1
    localparam int ENERGY_W = 2 * SAMPLE_W + 2;

    typedef logic signed [1:0] sym_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [ENERGY_W-1:0] energy_t;

    localparam sym_t SYM_PLUS  = 2'sb01;
    localparam sym_t SYM_MINUS = 2'sb11;
    localparam sym_t SYM_FILL  = 2'sb00;      // Sits in histories until real symbols arrive

    // State 0 ends in +1 and state 1 ends in -1
    localparam sym_t [1:0] STATE_TAG = {SYM_MINUS, SYM_PLUS};

    // One candidate or survivor path through the trellis
    typedef struct packed {
        energy_t            energy;
        sym_t [H_DEPTH-1:0] hist;             // hist[0] is the newest symbol
    } path_t;

endpackage
